// File: hw/mtx_pkg.sv
package mtx_pkg;

  localparam int DATA_WIDTH = 16;
  localparam int PHASE_WIDTH = 24;
  localparam int GPIO_WIDTH = 12;
  localparam int LUT_ADDR_WIDTH = 5;

  // Quadrant bits plus the quarter-wave address.
  localparam int PHASE_IDX_WIDTH = LUT_ADDR_WIDTH + 2;
  localparam logic [PHASE_IDX_WIDTH-1:0] QUARTER_TURN = 1 << LUT_ADDR_WIDTH;

  localparam logic signed [DATA_WIDTH-1:0] SYNC_AMP = 16'sd16384;

  typedef enum logic [2:0] {
    IDLE,
    PRE_POS,
    PRE_NEG,
    MUTE,
    RUN
  } sync_state_t;

  typedef union packed {
    logic [GPIO_WIDTH-1:0] raw;
    struct packed {
      logic tx_on;
      logic scan_id;
      logic rsvd9;
      logic phi;
      logic rsvd7;
      logic phi_bar;
      logic rsvd5;
      logic data_in;
      logic rsvd3;
      logic load_chip;
      logic rsvd1;
      logic synch_out;
    } pin;
  } gpio_word_u;

  localparam logic [GPIO_WIDTH-1:0] GPIO_DDR = 12'hd55;

  // Samples taken at half-step offsets so the quarter folds cleanly.
  localparam logic [DATA_WIDTH-2:0] SINE_QTR [2**LUT_ADDR_WIDTH] = '{
    15'd804,   15'd2411,  15'd4011,  15'd5602,
    15'd7179,  15'd8739,  15'd10278, 15'd11793,
    15'd13279, 15'd14732, 15'd16151, 15'd17530,
    15'd18868, 15'd20159, 15'd21403, 15'd22594,
    15'd23731, 15'd24812, 15'd25832, 15'd26790,
    15'd27683, 15'd28510, 15'd29268, 15'd29956,
    15'd30571, 15'd31113, 15'd31580, 15'd31971,
    15'd32285, 15'd32521, 15'd32678, 15'd32757
  };

  function automatic logic signed [DATA_WIDTH-1:0] sine_at(input logic [PHASE_IDX_WIDTH-1:0] p);
    logic [LUT_ADDR_WIDTH-1:0] idx;
    logic signed [DATA_WIDTH-1:0] mag;
    // Odd quadrants run the table backwards and the upper half is negated.
    idx = p[LUT_ADDR_WIDTH] ? ~p[LUT_ADDR_WIDTH-1:0] : p[LUT_ADDR_WIDTH-1:0];
    mag = DATA_WIDTH'(SINE_QTR[idx]);
    return p[LUT_ADDR_WIDTH+1] ? -mag : mag;
  endfunction

  function automatic logic signed [DATA_WIDTH-1:0] cosine_at(input logic [PHASE_IDX_WIDTH-1:0] p);
    return sine_at(p + QUARTER_TURN);
  endfunction

endpackage

// File: hw/scan_if.sv
interface scan_if;

  logic scan_id;
  logic phi;
  logic phi_bar;
  logic data_in;
  logic load_chip;

  modport source (
    output scan_id,
    output phi,
    output phi_bar,
    output data_in,
    output load_chip
  );

  modport sink (
    input scan_id,
    input phi,
    input phi_bar,
    input data_in,
    input load_chip
  );

endinterface

// File: hw/tone_gen.sv
module tone_gen #(
  parameter int NSYMB = 8,
  parameter int SIG_LEN = 1024,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] DPH_INC = 24'd16384,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] FREQ_SHIFT = 24'd8192,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] START_PH = 24'h000000
) (
  input  logic clk,
  input  logic reset,
  input  logic tone_hold,
  output logic frame_done,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] itx_raw,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] qtx_raw,
  output logic [mtx_pkg::PHASE_WIDTH-1:0] ph,
  output logic [$clog2(NSYMB+1)-1:0] symb_n
);

  import mtx_pkg::*;

  localparam int SAMP_WIDTH = $clog2(SIG_LEN + 1);
  localparam int SYMB_WIDTH = $clog2(NSYMB + 1);

  logic [PHASE_WIDTH-1:0] step;
  logic [SAMP_WIDTH-1:0] samp_cnt;
  logic symb_end;
  logic frame_end;
  logic [PHASE_IDX_WIDTH-1:0] lut_ph;

  // Last sample of the symbol, and of the last symbol in the frame.
  assign symb_end = samp_cnt == SAMP_WIDTH'(SIG_LEN - 1);
  assign frame_end = symb_end && (symb_n == SYMB_WIDTH'(NSYMB - 1));

  assign frame_done = frame_end && !tone_hold;

  always_ff @(posedge clk) begin
    if (reset || tone_hold) begin
      ph <= START_PH;
      step <= DPH_INC;
      samp_cnt <= '0;
      symb_n <= '0;
    end else begin
      ph <= ph + step;
      if (symb_end) begin
        samp_cnt <= '0;
        if (frame_end) begin
          symb_n <= '0;
          step <= DPH_INC;
        end else begin
          // Next symbol hops up by one frequency step.
          symb_n <= symb_n + 1'b1;
          step <= step + FREQ_SHIFT;
        end
      end else begin
        samp_cnt <= samp_cnt + 1'b1;
      end
    end
  end

  // Top phase bits address the sine table.
  assign lut_ph = ph[PHASE_WIDTH-1 -: PHASE_IDX_WIDTH];

  always_comb begin
    itx_raw = cosine_at(lut_ph);
    qtx_raw = sine_at(lut_ph);
  end

endmodule

// File: hw/hop_scan.sv
module hop_scan #(
  parameter int NTX_BITS = 78,
  parameter int SCAN_DIV = 20,
  parameter int BIT_CNT_WIDTH = 7
) (
  input  logic clk,
  input  logic reset,
  input  logic scan_hold,
  input  logic [NTX_BITS-1:0] tx_bits,
  scan_if.source scan,
  output logic [BIT_CNT_WIDTH-1:0] nbits_cnt
);

  localparam int DIV_WIDTH = $clog2(SCAN_DIV + 1);

  // Per-bit steps.
  localparam logic [1:0] PH_DATA = 2'd0;
  localparam logic [1:0] PH_PHI = 2'd1;
  localparam logic [1:0] PH_PHIB = 2'd2;

  logic [DIV_WIDTH-1:0] div_cnt;
  logic tick;
  logic [1:0] bit_ph;
  logic done;

  assign tick = div_cnt == DIV_WIDTH'(SCAN_DIV - 1);

  always_ff @(posedge clk) begin
    if (reset || scan_hold) begin
      div_cnt <= '0;
      bit_ph <= PH_DATA;
      done <= 1'b0;
      nbits_cnt <= '0;
      scan.scan_id <= 1'b0;
      scan.phi <= 1'b0;
      scan.phi_bar <= 1'b0;
      scan.data_in <= 1'b0;
      scan.load_chip <= 1'b0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (tick) begin
        // Load pulse lasts a single tick.
        scan.load_chip <= 1'b0;
        if (!done) begin
          case (bit_ph)
            PH_DATA: begin
              scan.phi_bar <= 1'b0;
              if (nbits_cnt == BIT_CNT_WIDTH'(NTX_BITS)) begin
                scan.scan_id <= 1'b0;
                scan.data_in <= 1'b0;
                scan.load_chip <= 1'b1;
                done <= 1'b1;
              end else begin
                scan.scan_id <= 1'b1;
                scan.data_in <= tx_bits[nbits_cnt];
                bit_ph <= PH_PHI;
              end
            end
            PH_PHI: begin
              scan.phi <= 1'b1;
              bit_ph <= PH_PHIB;
            end
            PH_PHIB: begin
              scan.phi <= 1'b0;
              scan.phi_bar <= 1'b1;
              nbits_cnt <= nbits_cnt + 1'b1;
              bit_ph <= PH_DATA;
            end
            default: begin
              bit_ph <= PH_DATA;
            end
          endcase
        end
      end
    end
  end

endmodule

// File: hw/sync_seq.sv
module sync_seq #(
  parameter int SYNC_LEN = 16384
) (
  input  logic clk,
  input  logic reset,
  input  logic frame_done,
  output logic tone_hold,
  output logic scan_hold,
  output logic mute,
  output logic rx_sync,
  output logic [2*mtx_pkg::DATA_WIDTH-1:0] rx_sync_data
);

  import mtx_pkg::*;

  localparam int SLOT_WIDTH = $clog2(SYNC_LEN + 1);

  sync_state_t state;
  logic [SLOT_WIDTH-1:0] slot_cnt;
  logic slot_end;
  logic in_slot;
  logic signed [DATA_WIDTH-1:0] amp;

  assign in_slot = (state == PRE_POS) || (state == PRE_NEG) || (state == MUTE);
  assign slot_end = slot_cnt == SLOT_WIDTH'(SYNC_LEN - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      slot_cnt <= '0;
    end else begin
      if (in_slot && !slot_end) begin
        slot_cnt <= slot_cnt + 1'b1;
      end else begin
        slot_cnt <= '0;
      end
      case (state)
        IDLE: state <= PRE_POS;
        PRE_POS: if (slot_end) state <= PRE_NEG;
        PRE_NEG: if (slot_end) state <= MUTE;
        MUTE: if (slot_end) state <= RUN;
        RUN: if (frame_done) state <= PRE_POS;
        default: state <= IDLE;
      endcase
    end
  end

  assign tone_hold = state != RUN;
  assign mute = state != RUN;
  // Scan engine starts with the negative preamble slot.
  assign scan_hold = (state == IDLE) || (state == PRE_POS);
  assign rx_sync = (state == PRE_POS) || (state == PRE_NEG);

  always_comb begin
    case (state)
      PRE_POS: amp = SYNC_AMP;
      PRE_NEG: amp = -SYNC_AMP;
      default: amp = '0;
    endcase
  end

  assign rx_sync_data = {amp, {DATA_WIDTH{1'b0}}};

endmodule

// File: hw/gpio_pins.sv
module gpio_pins (
  input  logic clk,
  input  logic reset,
  scan_if.sink scan,
  input  logic rx_sync,
  input  logic mute,
  input  logic signed [mtx_pkg::DATA_WIDTH-1:0] itx_raw,
  input  logic signed [mtx_pkg::DATA_WIDTH-1:0] qtx_raw,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] itx,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] qtx,
  output logic tx_valid,
  output logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_out,
  output logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_ddr
);

  import mtx_pkg::*;

  gpio_word_u pins_next;
  gpio_word_u pins_q;

  always_comb begin
    pins_next.raw = '0;
    pins_next.pin.synch_out = rx_sync;
    pins_next.pin.load_chip = scan.load_chip;
    pins_next.pin.data_in = scan.data_in;
    pins_next.pin.phi_bar = scan.phi_bar;
    pins_next.pin.phi = scan.phi;
    pins_next.pin.scan_id = scan.scan_id;
    pins_next.pin.tx_on = !mute;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pins_q.raw <= '0;
    end else begin
      pins_q <= pins_next;
    end
  end

  // Only output-direction pins are driven.
  assign fp_gpio_out = pins_q.raw & GPIO_DDR;
  assign fp_gpio_ddr = GPIO_DDR;

  assign tx_valid = !mute;
  assign itx = mute ? '0 : itx_raw;
  assign qtx = mute ? '0 : qtx_raw;

endmodule

// File: hw/mtx_ctrl.sv
module mtx_ctrl #(
  parameter int NSYMB = 8,
  parameter int SIG_LEN = 1024,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] DPH_INC = 24'd16384,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] FREQ_SHIFT = 24'd8192,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] START_PH = 24'h000000,
  parameter int SYNC_LEN = 16384,
  parameter int NTX_BITS = 78,
  parameter int SCAN_DIV = 20,
  parameter int BIT_CNT_WIDTH = 7
) (
  input  logic clk,
  input  logic reset,
  input  logic [NTX_BITS-1:0] tx_bits,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] itx,
  output logic signed [mtx_pkg::DATA_WIDTH-1:0] qtx,
  output logic tx_valid,
  output logic rx_sync,
  output logic [2*mtx_pkg::DATA_WIDTH-1:0] rx_sync_data,
  output logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_out,
  output logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_ddr,
  output logic [BIT_CNT_WIDTH-1:0] ntx_bits_cnt,
  // Debug.
  output logic [mtx_pkg::PHASE_WIDTH-1:0] ph,
  output logic [$clog2(NSYMB+1)-1:0] symb_n
);

  import mtx_pkg::*;

  logic tone_hold;
  logic scan_hold;
  logic frame_done;
  logic mute;
  logic signed [DATA_WIDTH-1:0] itx_raw;
  logic signed [DATA_WIDTH-1:0] qtx_raw;

  scan_if scan_bus ();

  sync_seq #(
    .SYNC_LEN(SYNC_LEN)
  ) u_sync_seq (
    .clk(clk),
    .reset(reset),
    .frame_done(frame_done),
    .tone_hold(tone_hold),
    .scan_hold(scan_hold),
    .mute(mute),
    .rx_sync(rx_sync),
    .rx_sync_data(rx_sync_data)
  );

  tone_gen #(
    .NSYMB(NSYMB),
    .SIG_LEN(SIG_LEN),
    .DPH_INC(DPH_INC),
    .FREQ_SHIFT(FREQ_SHIFT),
    .START_PH(START_PH)
  ) u_tone_gen (
    .clk(clk),
    .reset(reset),
    .tone_hold(tone_hold),
    .frame_done(frame_done),
    .itx_raw(itx_raw),
    .qtx_raw(qtx_raw),
    .ph(ph),
    .symb_n(symb_n)
  );

  hop_scan #(
    .NTX_BITS(NTX_BITS),
    .SCAN_DIV(SCAN_DIV),
    .BIT_CNT_WIDTH(BIT_CNT_WIDTH)
  ) u_hop_scan (
    .clk(clk),
    .reset(reset),
    .scan_hold(scan_hold),
    .tx_bits(tx_bits),
    .scan(scan_bus.source),
    .nbits_cnt(ntx_bits_cnt)
  );

  gpio_pins u_gpio_pins (
    .clk(clk),
    .reset(reset),
    .scan(scan_bus.sink),
    .rx_sync(rx_sync),
    .mute(mute),
    .itx_raw(itx_raw),
    .qtx_raw(qtx_raw),
    .itx(itx),
    .qtx(qtx),
    .tx_valid(tx_valid),
    .fp_gpio_out(fp_gpio_out),
    .fp_gpio_ddr(fp_gpio_ddr)
  );

endmodule

// File: dv/mtx_ctrl_assertions.sv
module mtx_ctrl_assertions #(
  parameter int NSYMB = 8,
  parameter int SIG_LEN = 1024,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] DPH_INC = 24'd16384,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] FREQ_SHIFT = 24'd8192,
  parameter logic [mtx_pkg::PHASE_WIDTH-1:0] START_PH = 24'h000000,
  parameter int SYNC_LEN = 16384,
  parameter int NTX_BITS = 78,
  parameter int BIT_CNT_WIDTH = 7
) (
  input logic clk,
  input logic reset,
  input logic [NTX_BITS-1:0] tx_bits,
  input logic signed [mtx_pkg::DATA_WIDTH-1:0] itx,
  input logic signed [mtx_pkg::DATA_WIDTH-1:0] qtx,
  input logic tx_valid,
  input logic rx_sync,
  input logic [2*mtx_pkg::DATA_WIDTH-1:0] rx_sync_data,
  input logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_out,
  input logic [mtx_pkg::GPIO_WIDTH-1:0] fp_gpio_ddr,
  input logic [BIT_CNT_WIDTH-1:0] ntx_bits_cnt,
  input logic [mtx_pkg::PHASE_WIDTH-1:0] ph,
  input logic [$clog2(NSYMB+1)-1:0] symb_n
);

  import mtx_pkg::*;

  localparam int FRAME_LEN = NSYMB * SIG_LEN;
  localparam logic [PHASE_IDX_WIDTH-1:0] QUARTER = PHASE_IDX_WIDTH'(2 ** LUT_ADDR_WIDTH);

  int error_count;
  int sync_run;
  int quiet_run;
  int valid_run;
  gpio_word_u pins;
  logic signed [DATA_WIDTH-1:0] sync_upper;
  logic sync_positive;
  logic [PHASE_WIDTH-1:0] step_now;
  logic [PHASE_IDX_WIDTH-1:0] lut_ph;

  initial error_count = 0;

  task automatic report_failure(input string msg);
    error_count++;
    $error("%s", msg);
  endtask

  function automatic logic signed [DATA_WIDTH-1:0] wave_sample(
    input logic [PHASE_IDX_WIDTH-1:0] p
  );
    logic [LUT_ADDR_WIDTH-1:0] addr;
    logic signed [DATA_WIDTH-1:0] mag;
    // Second and fourth quadrants read the quarter wave backwards.
    addr = p[LUT_ADDR_WIDTH] ?
      LUT_ADDR_WIDTH'(2 ** LUT_ADDR_WIDTH - 1) - p[LUT_ADDR_WIDTH-1:0] :
      p[LUT_ADDR_WIDTH-1:0];
    mag = DATA_WIDTH'(SINE_QTR[addr]);
    return p[PHASE_IDX_WIDTH-1] ? -mag : mag;
  endfunction

  assign pins.raw = fp_gpio_out;
  assign sync_upper = rx_sync_data[2*DATA_WIDTH-1 -: DATA_WIDTH];
  assign sync_positive = !sync_upper[DATA_WIDTH-1] && (sync_upper != '0);
  assign step_now = DPH_INC + PHASE_WIDTH'(symb_n) * FREQ_SHIFT;
  assign lut_ph = ph[PHASE_WIDTH-1 -: PHASE_IDX_WIDTH];

  // Each run length counts the earlier cycles of the current run.
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_run <= 0;
      quiet_run <= 0;
      valid_run <= 0;
    end else begin
      sync_run <= rx_sync ? sync_run + 1 : 0;
      quiet_run <= (!rx_sync && !tx_valid) ? quiet_run + 1 : 0;
      valid_run <= tx_valid ? valid_run + 1 : 0;
    end
  end

  a_sync_max: assert property (@(posedge clk) disable iff (reset)
    rx_sync |-> sync_run < 2 * SYNC_LEN)
    else report_failure("rx_sync stayed high longer than two sync slots");
  a_sync_len: assert property (@(posedge clk) disable iff (reset)
    $fell(rx_sync) |-> sync_run == 2 * SYNC_LEN)
    else report_failure("rx_sync fell before two full sync slots");
  a_sync_pos: assert property (@(posedge clk) disable iff (reset)
    rx_sync && sync_run < SYNC_LEN |-> sync_upper == SYNC_AMP)
    else report_failure($sformatf("Mismatch at %0t: positive preamble amplitude", $time));
  a_sync_neg: assert property (@(posedge clk) disable iff (reset)
    rx_sync && sync_run >= SYNC_LEN |-> sync_upper == -SYNC_AMP)
    else report_failure($sformatf("Mismatch at %0t: negative preamble amplitude", $time));
  a_sync_low: assert property (@(posedge clk) disable iff (reset)
    rx_sync_data[DATA_WIDTH-1:0] == '0)
    else report_failure($sformatf("Mismatch at %0t: rx_sync_data lower half", $time));
  a_flag_pins: assert property (@(posedge clk) disable iff (reset)
    pins.pin.synch_out == $past(rx_sync) && pins.pin.tx_on == $past(tx_valid))
    else report_failure($sformatf("Mismatch at %0t: sync or tx_on pin", $time));
  a_mute_iq: assert property (@(posedge clk) disable iff (reset)
    !tx_valid |-> itx == '0 && qtx == '0)
    else report_failure($sformatf("Mismatch at %0t: I/Q not zero while muted", $time));
  a_mute_len: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_valid) |-> quiet_run == SYNC_LEN)
    else report_failure("tx_valid rose without a full mute slot after the preamble");
  a_mute_max: assert property (@(posedge clk) disable iff (reset)
    !rx_sync && !tx_valid |-> quiet_run < SYNC_LEN)
    else report_failure("mute slot lasted longer than one sync slot");
  a_start_ph: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_valid) |-> ph == START_PH)
    else report_failure($sformatf("Mismatch at %0t: phase at frame start", $time));
  a_iq: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> itx == wave_sample(lut_ph + QUARTER) && qtx == wave_sample(lut_ph))
    else report_failure($sformatf("Mismatch at %0t: I/Q sample for phase", $time));
  a_ph_step: assert property (@(posedge clk) disable iff (reset)
    tx_valid && $past(tx_valid) |-> ph == $past(ph) + $past(step_now))
    else report_failure($sformatf("Mismatch at %0t: phase step", $time));
  a_frame_len: assert property (@(posedge clk) disable iff (reset)
    $fell(tx_valid) |-> valid_run == FRAME_LEN && $rose(rx_sync))
    else report_failure("frame ended early or the next preamble did not follow");
  a_frame_max: assert property (@(posedge clk) disable iff (reset)
    tx_valid |-> valid_run < FRAME_LEN)
    else report_failure("tx_valid stayed high past the end of the frame");
  a_scan_data: assert property (@(posedge clk) disable iff (reset)
    $rose(pins.pin.phi) |-> pins.pin.scan_id &&
    pins.pin.data_in == tx_bits[ntx_bits_cnt])
    else report_failure($sformatf("Mismatch at %0t: scan data or scan_id pin", $time));
  a_phi_overlap: assert property (@(posedge clk) disable iff (reset)
    !(pins.pin.phi && pins.pin.phi_bar))
    else report_failure("phi and phi_bar were high together");
  a_load: assert property (@(posedge clk) disable iff (reset)
    $rose(pins.pin.load_chip) |-> ntx_bits_cnt == BIT_CNT_WIDTH'(NTX_BITS))
    else report_failure("load_chip rose before all bits were shifted");
  // The counter clears one cycle into the positive slot.
  a_scan_idle: assert property (@(posedge clk) disable iff (reset)
    sync_positive && $past(sync_positive) |-> ntx_bits_cnt == '0)
    else report_failure($sformatf("Mismatch at %0t: bit count in positive slot", $time));
  a_dirs: assert property (@(posedge clk) disable iff (reset)
    fp_gpio_ddr == GPIO_DDR && {pins.pin.rsvd9, pins.pin.rsvd7, pins.pin.rsvd5,
    pins.pin.rsvd3, pins.pin.rsvd1} == '0)
    else report_failure($sformatf("Mismatch at %0t: direction or reserved pins", $time));

endmodule

// File: dv/tb_mtx_ctrl.sv
module tb_mtx_ctrl;

  import mtx_pkg::*;

  localparam int SIG_LEN = 8;
  // Frame long enough for the whole scan word to shift out.
  localparam int NSYMB = 96;
  localparam int SYNC_LEN = 20;
  localparam int SCAN_DIV = 3;
  localparam int NTX_BITS = 78;
  localparam int BIT_CNT_WIDTH = 7;
  localparam logic [PHASE_WIDTH-1:0] DPH_INC = 24'h02_0000;
  localparam logic [PHASE_WIDTH-1:0] FREQ_SHIFT = 24'h00_1800;
  localparam logic [PHASE_WIDTH-1:0] START_PH = 24'h40_0000;
  localparam logic [31:0] SEED = 32'h27f6_b6f0;
  localparam int WAIT_LIMIT = 2000;

  localparam int CP_SYNC_RISE = 0;
  localparam int CP_VALID_RISE = 1;
  localparam int CP_SCAN_DONE = 2;
  localparam int CP_FRAME_END = 3;
  localparam int CP_SYNC_RISE2 = 4;
  localparam int CP_SYNC_FALL2 = 5;

  logic clk;
  logic reset;
  logic [NTX_BITS-1:0] tx_bits;
  logic signed [DATA_WIDTH-1:0] itx;
  logic signed [DATA_WIDTH-1:0] qtx;
  logic tx_valid;
  logic rx_sync;
  logic [2*DATA_WIDTH-1:0] rx_sync_data;
  logic [GPIO_WIDTH-1:0] fp_gpio_out;
  logic [GPIO_WIDTH-1:0] fp_gpio_ddr;
  logic [BIT_CNT_WIDTH-1:0] ntx_bits_cnt;
  logic [PHASE_WIDTH-1:0] ph;
  logic [$clog2(NSYMB+1)-1:0] symb_n;

  logic sync_q;
  logic valid_q;
  int sync_rises;
  int sync_falls;
  int valid_rises;
  int valid_falls;
  int tests_ok;
  int tests_bad;

  mtx_ctrl #(
    .NSYMB(NSYMB),
    .SIG_LEN(SIG_LEN),
    .DPH_INC(DPH_INC),
    .FREQ_SHIFT(FREQ_SHIFT),
    .START_PH(START_PH),
    .SYNC_LEN(SYNC_LEN),
    .NTX_BITS(NTX_BITS),
    .SCAN_DIV(SCAN_DIV),
    .BIT_CNT_WIDTH(BIT_CNT_WIDTH)
  ) uut (.*);

  bind mtx_ctrl mtx_ctrl_assertions #(
    .NSYMB(NSYMB),
    .SIG_LEN(SIG_LEN),
    .DPH_INC(DPH_INC),
    .FREQ_SHIFT(FREQ_SHIFT),
    .START_PH(START_PH),
    .SYNC_LEN(SYNC_LEN),
    .NTX_BITS(NTX_BITS),
    .BIT_CNT_WIDTH(BIT_CNT_WIDTH)
  ) u_checks (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Edge counts are taken at the rising edge and read half a cycle later.
  always_ff @(posedge clk) begin
    sync_q <= rx_sync;
    valid_q <= tx_valid;
    if (reset) begin
      sync_rises <= 0;
      sync_falls <= 0;
      valid_rises <= 0;
      valid_falls <= 0;
    end else begin
      if (rx_sync && !sync_q) sync_rises <= sync_rises + 1;
      if (!rx_sync && sync_q) sync_falls <= sync_falls + 1;
      if (tx_valid && !valid_q) valid_rises <= valid_rises + 1;
      if (!tx_valid && valid_q) valid_falls <= valid_falls + 1;
    end
  end

  function automatic bit checkpoint_reached(input int kind);
    case (kind)
      CP_SYNC_RISE: return sync_rises >= 1;
      CP_VALID_RISE: return valid_rises >= 1;
      CP_SCAN_DONE: return ntx_bits_cnt == BIT_CNT_WIDTH'(NTX_BITS);
      CP_FRAME_END: return valid_falls >= 1;
      CP_SYNC_RISE2: return sync_rises >= 2;
      default: return sync_falls >= 2;
    endcase
  endfunction

  task automatic run_test(input string name, input int kind);
    int cycles;
    int errors_before;
    cycles = 0;
    errors_before = uut.u_checks.error_count;
    while (!checkpoint_reached(kind) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!checkpoint_reached(kind)) begin
      tests_bad++;
      $display("[%0t] %s: gave up after %0d cycles, checkpoint never reached",
               $time, name, cycles);
    end else if (uut.u_checks.error_count != errors_before) begin
      tests_bad++;
      $display("[%0t] %s: reached with %0d assertion failures", $time, name,
               uut.u_checks.error_count - errors_before);
    end else begin
      tests_ok++;
      $display("[%0t] %s: ok after %0d cycles", $time, name, cycles);
    end
  endtask

  initial begin
    logic [95:0] draw;
    tests_ok = 0;
    tests_bad = 0;
    reset = 1'b1;
    draw[31:0] = $urandom(SEED);
    draw[63:32] = $urandom();
    draw[95:64] = $urandom();
    tx_bits = draw[NTX_BITS-1:0];
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    run_test("preamble start", CP_SYNC_RISE);
    run_test("first tx_valid rise", CP_VALID_RISE);
    run_test("scan word shifted out", CP_SCAN_DONE);
    run_test("first frame end", CP_FRAME_END);
    run_test("second preamble start", CP_SYNC_RISE2);
    run_test("second preamble end", CP_SYNC_FALL2);

    $display("summary: %0d ok, %0d bad, %0d assertion failures",
             tests_ok, tests_bad, uut.u_checks.error_count);
    if (tests_bad == 0 && uut.u_checks.error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: project.f
hw/mtx_pkg.sv
hw/scan_if.sv
hw/tone_gen.sv
hw/hop_scan.sv
hw/sync_seq.sv
hw/gpio_pins.sv
hw/mtx_ctrl.sv
dv/mtx_ctrl_assertions.sv
dv/tb_mtx_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_mtx_ctrl
FILELIST := project.f
RUNFLAGS := +verilator+error+limit+1000

OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) | tee /dev/stderr | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
